//--- logic/sat_defines.svh
`ifndef SAT_DEFINES_SVH
`define SAT_DEFINES_SVH

// Number of solver engines on the broadcast
`define NUM_ENGINE 4

// Number of variables, a literal carries log2 of this plus a sign bit
`define LIT_IDX_MAX 16

// Queue depths
`define UCQ_DEPTH 8
`define IMPQ_DEPTH 4

`endif

//--- logic/sat_pkg.sv
`include "sat_defines.svh"

package sat_pkg;

    // Top bit is the polarity (1 = negative)
    // Negative literals carry the two's complement of the index in the low bits
    typedef logic [$clog2(`LIT_IDX_MAX):0] lit_t;

    // Arbiter FSM states
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        READY = 2'd1,
        PROC  = 2'd2,
        DONE  = 2'd3
    } uc_arb_t;

endpackage

//--- logic/uc_queue.sv
`timescale 1ns/10ps

module uc_queue #(
    parameter int DEPTH = 8
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          push,
    input  logic          pop,
    input  sat_pkg::lit_t wdata,
    output sat_pkg::lit_t rdata,
    output logic          empty,
    output logic          full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    sat_pkg::lit_t    mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    // Push on full and pop on empty are dropped
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign empty = (count == '0);
    assign full  = (count == CNT_W'(DEPTH));

    // Head is visible without read latency
    assign rdata = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

//--- logic/implied_queue_bank.sv
`timescale 1ns/10ps
`include "sat_defines.svh"

module implied_queue_bank (
    input  logic                               clk,
    input  logic                               rst,
    input  logic          [`NUM_ENGINE-1:0]    imp_push,
    input  sat_pkg::lit_t [`NUM_ENGINE-1:0]    imp_lit,
    input  logic          [`NUM_ENGINE-1:0]    q_pop,
    output logic          [`NUM_ENGINE-1:0]    q_empty,
    output logic          [`NUM_ENGINE-1:0]    q_full,
    output sat_pkg::lit_t [`NUM_ENGINE-1:0]    q_lit
);

    // One implied queue per engine, so a busy engine never blocks the others
    for (genvar i = 0; i < `NUM_ENGINE; i++) begin : g_impq
        sat_pkg::lit_t head;

        uc_queue #(
            .DEPTH (`IMPQ_DEPTH)
        ) u_impq (
            .clk   (clk),
            .rst   (rst),
            .push  (imp_push[i]),
            .pop   (q_pop[i]),
            .wdata (imp_lit[i]),
            .rdata (head),
            .empty (q_empty[i]),
            .full  (q_full[i])
        );

        assign q_lit[i] = head;
    end

endmodule

//--- logic/engine_select.sv
`timescale 1ns/10ps
`include "sat_defines.svh"

module engine_select (
    input  logic                               input_mode,
    input  logic          [`NUM_ENGINE-1:0]    engmask,
    input  logic          [`NUM_ENGINE-1:0]    q_empty,
    input  sat_pkg::lit_t [`NUM_ENGINE-1:0]    q_lit,
    input  logic                               sel_take,
    output logic                               sel_valid,
    output logic                               sel_empty,
    output sat_pkg::lit_t                      sel_lit,
    output logic          [`NUM_ENGINE-1:0]    q_pop
);

    logic [`NUM_ENGINE-1:0] pq_pick;
    logic [`NUM_ENGINE-1:0] pick;

    // Priority encoder, lowest non-empty queue wins
    always_comb begin
        pq_pick = '0;
        for (int i = 0; i < `NUM_ENGINE; i++) begin
            if (!q_empty[i] && pq_pick == '0) begin
                pq_pick[i] = 1'b1;
            end
        end
    end

    // Mode 1 is PQ mode, mode 0 follows the one-hot mask
    assign pick = input_mode ? pq_pick : engmask;

    always_comb begin
        sel_lit = '0;
        for (int i = 0; i < `NUM_ENGINE; i++) begin
            if (pick[i]) begin
                sel_lit = q_lit[i];
            end
        end
    end

    assign sel_empty = ~|(pick & ~q_empty);
    assign sel_valid = ~sel_empty;

    // Take pops the chosen queue in the same cycle
    assign q_pop = pick & ~q_empty & {`NUM_ENGINE{sel_take}};

endmodule

//--- logic/uc_arbiter.sv
`timescale 1ns/10ps
`include "sat_defines.svh"

module uc_arbiter (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        input_mode,
    input  logic                        mem_valid,
    input  logic                        mem_done,
    input  sat_pkg::lit_t               mem_lit,
    input  logic                        sel_valid,
    input  logic                        sel_empty,
    input  sat_pkg::lit_t               sel_lit,
    input  logic [`NUM_ENGINE-1:0]      eng_stall,
    input  logic                        eng_processed,
    input  logic [`NUM_ENGINE:0]        eng_full,
    output logic                        sel_take,
    output logic [`NUM_ENGINE-1:0]      engmask,
    output sat_pkg::lit_t               out_lit,
    output logic                        out_push,
    output logic                        conflict
);

    localparam int IDX_W = $clog2(`LIT_IDX_MAX);

    sat_pkg::uc_arb_t state;
    sat_pkg::uc_arb_t next_state;

    logic [`NUM_ENGINE-1:0] engmask_r;
    logic [`NUM_ENGINE-1:0] engmask_w;

    logic          push;
    sat_pkg::lit_t push_lit;
    logic          ucq_empty;
    logic          ucq_full;

    // Per variable: bit 0 seen positive, bit 1 seen negative
    logic [`LIT_IDX_MAX-1:0][1:0] table_r;
    logic [`LIT_IDX_MAX-1:0][1:0] table_w;
    logic [`LIT_IDX_MAX-1:0]      detect;

    logic             lit_neg;
    logic [IDX_W-1:0] lit_idx;

    assign engmask  = engmask_r;
    assign conflict = (state == sat_pkg::DONE);

    // Decode the literal that enters the output queue
    assign lit_neg = push_lit[IDX_W];
    assign lit_idx = lit_neg ? IDX_W'(~push_lit[IDX_W-1:0] + 1'b1) : push_lit[IDX_W-1:0];

    uc_queue #(
        .DEPTH (`UCQ_DEPTH)
    ) u_ucq (
        .clk   (clk),
        .rst   (rst),
        .push  (push),
        .pop   (out_push),
        .wdata (push_lit),
        .rdata (out_lit),
        .empty (ucq_empty),
        .full  (ucq_full)
    );

    // Broadcast while at least one engine has room
    assign out_push = !ucq_empty && !(&eng_full);

    always_comb begin
        next_state = state;
        engmask_w  = engmask_r;
        sel_take   = 1'b0;
        push       = 1'b0;
        push_lit   = sel_lit;

        case (state)
            sat_pkg::IDLE: begin
                engmask_w = '0;
                push      = mem_valid && !ucq_full;
                push_lit  = mem_lit;
                if (mem_done) begin
                    next_state = sat_pkg::READY;
                end
            end
            sat_pkg::READY: begin
                if (|detect) begin
                    next_state = sat_pkg::DONE;
                end else if (input_mode) begin
                    sel_take = sel_valid && !ucq_full;
                    push     = sel_take;
                    // All engines idle and nothing pending, back to loading
                    if (!sel_take && &eng_stall && !eng_processed) begin
                        next_state = sat_pkg::IDLE;
                    end
                end else begin
                    engmask_w  = (engmask_r == '0) ? `NUM_ENGINE'(1)
                               : {engmask_r[`NUM_ENGINE-2:0], engmask_r[`NUM_ENGINE-1]};
                    next_state = sat_pkg::PROC;
                end
            end
            sat_pkg::PROC: begin
                sel_take   = !sel_empty && (engmask_r != '0) && !ucq_full;
                push       = sel_take;
                next_state = sat_pkg::READY;
            end
            sat_pkg::DONE: begin
                // Sticky until reset
                next_state = sat_pkg::DONE;
            end
            default: begin
                next_state = sat_pkg::IDLE;
            end
        endcase
    end

    always_comb begin
        table_w = table_r;
        if (push) begin
            table_w[lit_idx][lit_neg] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= sat_pkg::IDLE;
            engmask_r <= '0;
            table_r   <= '0;
            detect    <= '0;
        end else begin
            state     <= next_state;
            engmask_r <= engmask_w;
            table_r   <= table_w;
            for (int i = 0; i < `LIT_IDX_MAX; i++) begin
                detect[i] <= &table_w[i];
            end
        end
    end

endmodule

//--- logic/uc_subsystem.sv
`timescale 1ns/10ps
`include "sat_defines.svh"

module uc_subsystem (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               input_mode,
    input  logic                               mem_valid,
    input  logic                               mem_done,
    input  sat_pkg::lit_t                      mem_lit,
    input  logic          [`NUM_ENGINE-1:0]    imp_push,
    input  sat_pkg::lit_t [`NUM_ENGINE-1:0]    imp_lit,
    input  logic          [`NUM_ENGINE-1:0]    eng_stall,
    input  logic                               eng_processed,
    input  logic          [`NUM_ENGINE:0]      eng_full,
    output logic                               out_push,
    output sat_pkg::lit_t                      out_lit,
    output logic          [`NUM_ENGINE-1:0]    imp_full,
    output logic                               conflict
);

    logic          [`NUM_ENGINE-1:0] q_empty;
    logic          [`NUM_ENGINE-1:0] q_pop;
    sat_pkg::lit_t [`NUM_ENGINE-1:0] q_lit;
    logic          [`NUM_ENGINE-1:0] engmask;
    logic                            sel_valid;
    logic                            sel_empty;
    logic                            sel_take;
    sat_pkg::lit_t                   sel_lit;

    implied_queue_bank u_bank (
        .clk      (clk),
        .rst      (rst),
        .imp_push (imp_push),
        .imp_lit  (imp_lit),
        .q_pop    (q_pop),
        .q_empty  (q_empty),
        .q_full   (imp_full),
        .q_lit    (q_lit)
    );

    engine_select u_sel (
        .input_mode (input_mode),
        .engmask    (engmask),
        .q_empty    (q_empty),
        .q_lit      (q_lit),
        .sel_take   (sel_take),
        .sel_valid  (sel_valid),
        .sel_empty  (sel_empty),
        .sel_lit    (sel_lit),
        .q_pop      (q_pop)
    );

    uc_arbiter u_arb (
        .clk           (clk),
        .rst           (rst),
        .input_mode    (input_mode),
        .mem_valid     (mem_valid),
        .mem_done      (mem_done),
        .mem_lit       (mem_lit),
        .sel_valid     (sel_valid),
        .sel_empty     (sel_empty),
        .sel_lit       (sel_lit),
        .eng_stall     (eng_stall),
        .eng_processed (eng_processed),
        .eng_full      (eng_full),
        .sel_take      (sel_take),
        .engmask       (engmask),
        .out_lit       (out_lit),
        .out_push      (out_push),
        .conflict      (conflict)
    );

endmodule

//--- verification/uc_subsystem_props.sv
`timescale 1ns/10ps
`include "sat_defines.svh"

module uc_subsystem_props (
    input logic                         clk,
    input logic                         rst,
    input logic                         out_push,
    input logic                         ucq_empty,
    input logic [`NUM_ENGINE:0]         eng_full,
    input logic                         conflict,
    input logic [`NUM_ENGINE-1:0]       engmask,
    input sat_pkg::uc_arb_t             state,
    input logic [`LIT_IDX_MAX-1:0][1:0] polarity
);

    logic [`LIT_IDX_MAX-1:0] both_seen;

    // Variables recorded with both polarities
    always_comb begin
        for (int i = 0; i < `LIT_IDX_MAX; i++) begin
            both_seen[i] = polarity[i][0] && polarity[i][1];
        end
    end

    // Broadcast only from a non-empty queue with at least one engine free
    assert property (@(posedge clk) disable iff (rst)
        out_push |-> (!ucq_empty && !(&eng_full)))
        else $error("out_push with an empty output queue or every engine full");

    // Conflict is sticky until reset
    assert property (@(posedge clk) disable iff (rst) conflict |=> conflict)
        else $error("conflict fell without a reset");

    // DONE needs a variable that was seen with both polarities
    assert property (@(posedge clk) disable iff (rst)
        (state == sat_pkg::DONE) |-> (|both_seen))
        else $error("DONE state reached without an opposite pair in the table");

    assert property (@(posedge clk) $onehot0(engmask))
        else $error("engmask has more than one bit set");

endmodule

bind uc_arbiter uc_subsystem_props u_props (
    .clk       (clk),
    .rst       (rst),
    .out_push  (out_push),
    .ucq_empty (ucq_empty),
    .eng_full  (eng_full),
    .conflict  (conflict),
    .engmask   (engmask),
    .state     (state),
    .polarity  (table_r)
);

//--- verification/uc_subsystem_tb.sv
`timescale 1ns/10ps
`include "sat_defines.svh"

module uc_subsystem_tb;

    localparam int NSRC = `NUM_ENGINE + 1;

    logic                               clk;
    logic                               rst;
    logic                               input_mode;
    logic                               mem_valid;
    logic                               mem_done;
    sat_pkg::lit_t                      mem_lit;
    logic          [`NUM_ENGINE-1:0]    imp_push;
    sat_pkg::lit_t [`NUM_ENGINE-1:0]    imp_lit;
    logic          [`NUM_ENGINE-1:0]    eng_stall;
    logic                               eng_processed;
    logic          [`NUM_ENGINE:0]      eng_full;
    logic                               out_push;
    sat_pkg::lit_t                      out_lit;
    logic          [`NUM_ENGINE-1:0]    imp_full;
    logic                               conflict;

    // Records as read from the data file
    int rec_scen[$];
    int rec_mode[$];
    int rec_src[$];
    int rec_lit[$];
    int rec_conf[$];

    // Expected literals per source, 0 is memory and 1..N are the engines
    sat_pkg::lit_t exp_q[NSRC][$];

    logic [7:0] lfsr;
    logic       bp_enable;
    logic       loaded;
    logic       run_passed;
    logic       fail_shown;

    uc_subsystem dut0 (
        .clk           (clk),
        .rst           (rst),
        .input_mode    (input_mode),
        .mem_valid     (mem_valid),
        .mem_done      (mem_done),
        .mem_lit       (mem_lit),
        .imp_push      (imp_push),
        .imp_lit       (imp_lit),
        .eng_stall     (eng_stall),
        .eng_processed (eng_processed),
        .eng_full      (eng_full),
        .out_push      (out_push),
        .out_lit       (out_lit),
        .imp_full      (imp_full),
        .conflict      (conflict)
    );

    always #5 clk = ~clk;

    // Taps 8, 6, 5, 4
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    task automatic lfsr_bit(output logic b);
        lfsr = lfsr_next(lfsr);
        b    = lfsr[0];
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        fail_shown = 1'b1;
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            abort_run($sformatf("[FAIL] t=%0t %s expected=%0h actual=%0h",
                                $time, name, expected, actual));
        end
    endtask

    function automatic int pending();
        int n;
        n = 0;
        for (int s = 0; s < NSRC; s++) begin
            n += exp_q[s].size();
        end
        return n;
    endfunction

    // Next falling edge, then new back-pressure bits
    task automatic tick();
        logic a;
        logic b;
        @(negedge clk);
        if (bp_enable) begin
            lfsr_bit(a);
            lfsr_bit(b);
            if (a && b) begin
                eng_full = '1;
            end else begin
                for (int k = 0; k <= `NUM_ENGINE; k++) begin
                    lfsr_bit(a);
                    eng_full[k] = a;
                end
            end
        end else begin
            eng_full = '0;
        end
    endtask

    task automatic take_output(input sat_pkg::lit_t got);
        int            src;
        sat_pkg::lit_t want;
        src = -1;
        // Memory literals always leave before any implied literal
        if (exp_q[0].size() > 0) begin
            src = 0;
        end else begin
            for (int e = 1; e < NSRC; e++) begin
                if (src < 0 && exp_q[e].size() > 0 && exp_q[e][0] == got) begin
                    src = e;
                end
            end
            // No head matches, so compare with the first pending one
            for (int e = 1; e < NSRC; e++) begin
                if (src < 0 && exp_q[e].size() > 0) begin
                    src = e;
                end
            end
        end
        if (src < 0) begin
            abort_run($sformatf("Literal %0h was broadcast at %0t while none was pending",
                                got, $time));
        end else begin
            want = exp_q[src].pop_front();
            check("out_lit", 32'(want), 32'(got));
        end
    endtask

    // Outputs are sampled at the rising edge, before the DUT updates
    always @(posedge clk) begin
        if (!rst && out_push) begin
            if (&eng_full) begin
                check("out_push", 32'd0, 32'd1);
            end
            take_output(out_lit);
        end
    end

    task automatic run_scenario(input int first, input int last);
        int          e;
        logic [31:0] want_conf;
        logic        can_fill;
        want_conf  = 32'(rec_conf[first]);
        bp_enable  = 1'b0;
        rst        = 1'b1;
        input_mode = (rec_mode[first] != 0);
        for (int s = 0; s < NSRC; s++) begin
            exp_q[s].delete();
        end
        tick();
        tick();
        rst = 1'b0;
        check("conflict", 32'd0, 32'(conflict));
        check("out_push", 32'd0, 32'(out_push));
        check("imp_full", 32'd0, 32'(imp_full));
        bp_enable = 1'b1;
        // Loading phase, one memory literal per cycle
        for (int i = first; i < last; i++) begin
            if (rec_src[i] == 0) begin
                mem_valid = 1'b1;
                mem_lit   = sat_pkg::lit_t'(rec_lit[i]);
                exp_q[0].push_back(mem_lit);
                tick();
            end
        end
        mem_valid = 1'b0;
        mem_done  = 1'b1;
        tick();
        mem_done = 1'b0;
        for (int i = first; i < last; i++) begin
            if (rec_src[i] > 0) begin
                e = rec_src[i] - 1;
                // Hold the literal back while that engine's queue is full
                while (imp_full[e]) begin
                    // A full implied queue means a queue's worth is still unbroadcast
                    can_fill = (exp_q[rec_src[i]].size() >= `IMPQ_DEPTH);
                    check("imp_full", 32'(can_fill), 32'(imp_full[e]));
                    imp_push = '0;
                    tick();
                end
                imp_push    = '0;
                imp_push[e] = 1'b1;
                imp_lit[e]  = sat_pkg::lit_t'(rec_lit[i]);
                exp_q[rec_src[i]].push_back(imp_lit[e]);
                tick();
            end
        end
        imp_push = '0;
        // After a conflict the implied queues are no longer served
        while (exp_q[0].size() > 0 || (want_conf == 0 && pending() > 0)) begin
            tick();
        end
        bp_enable = 1'b0;
        repeat (`UCQ_DEPTH + 4) tick();
        check("conflict", want_conf, 32'(conflict));
        if (want_conf == 0) begin
            check("imp_full", 32'd0, 32'(imp_full));
        end
    endtask

    initial begin
        int    fd;
        int    s;
        int    m;
        int    src;
        int    l;
        int    c;
        int    i;
        int    j;
        string line;
        clk           = 1'b0;
        rst           = 1'b1;
        input_mode    = 1'b0;
        mem_valid     = 1'b0;
        mem_done      = 1'b0;
        mem_lit       = '0;
        imp_push      = '0;
        imp_lit       = '0;
        eng_stall     = '0;
        eng_processed = 1'b0;
        eng_full      = '0;
        lfsr          = 8'd86;
        bp_enable     = 1'b0;
        loaded        = 1'b0;
        run_passed    = 1'b0;
        fail_shown    = 1'b0;
        fd = $fopen("verification/uc_input.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open verification/uc_input.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            // Lines starting with # describe the columns
            if (line.len() > 1 && line[0] != "#") begin
                if ($sscanf(line, "%d %d %d %h %d", s, m, src, l, c) == 5) begin
                    rec_scen.push_back(s);
                    rec_mode.push_back(m);
                    rec_src.push_back(src);
                    rec_lit.push_back(l);
                    rec_conf.push_back(c);
                end
            end
        end
        $fclose(fd);
        if (rec_scen.size() == 0) begin
            abort_run("The data file holds no records");
        end
        loaded = 1'b1;
        i = 0;
        while (i < rec_scen.size()) begin
            j = i;
            while (j < rec_scen.size() && rec_scen[j] == rec_scen[i]) begin
                j++;
            end
            run_scenario(i, j);
            i = j;
        end
        run_passed = 1'b1;
        $display("Simulation completed successfully");
        $finish;
    end

    // Fifty cycles per record covers the slowest mask-mode drain
    initial begin
        wait (loaded);
        repeat (rec_scen.size() * 50) @(posedge clk);
        abort_run($sformatf("Timeout, the run did not finish within %0d cycles",
                            rec_scen.size() * 50));
    end

    final begin
        if (!run_passed && !fail_shown) begin
            $display("Simulation failed");
        end
    end

endmodule

//--- verilog.f
+incdir+logic
logic/sat_pkg.sv
logic/uc_queue.sv
logic/implied_queue_bank.sv
logic/engine_select.sv
logic/uc_arbiter.sv
logic/uc_subsystem.sv
verification/uc_subsystem_props.sv
verification/uc_subsystem_tb.sv

//--- Makefile
VERILATOR  := verilator
TOP        := uc_subsystem_tb
FILELIST   := verilog.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- verification/uc_input.txt
# scen mode src lit conf
# mode 0 mask 1 PQ, src 0 memory 1..4 engine 0..3, lit in hex, conf expected at the end
1 0 0 01 0
1 0 0 02 0
1 0 0 03 0
1 0 0 04 0
1 0 0 05 0
2 1 0 0F 0
2 1 1 07 0
2 1 2 0A 0
2 1 1 08 0
2 1 3 0B 0
2 1 4 0D 0
2 1 1 09 0
3 0 1 01 0
3 0 4 04 0
3 0 4 05 0
3 0 2 03 0
3 0 4 06 0
3 0 4 07 0
3 0 3 1E 0
3 0 4 08 0
3 0 1 09 0
4 0 0 03 1
4 0 0 1D 1
4 0 0 04 1
5 1 1 05 1
5 1 3 1B 1
6 1 0 1D 0
6 1 2 06 0
